// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       := tb_ecc_mem_subsys
FILELIST  := list.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1 || echo "=== FAIL ===" >> $(LOG)
	@cat $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then echo "simulation failed"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== ecc_bus_dec.sv ====
module ecc_bus_dec (
  // initiator side, carries check bits in the user field
  input  logic                          req_i,
  output logic                          gnt_o,
  input  logic [ecc_pkg::ADDR_W-1:0]    add_i,
  input  logic                          wen_i,
  input  logic [ecc_pkg::DATA_W-1:0]    data_i,
  input  logic [ecc_pkg::BE_W-1:0]      be_i,
  input  logic [ecc_pkg::ECC_W-1:0]     user_i,
  output logic [ecc_pkg::DATA_W-1:0]    r_data_o,
  output logic [ecc_pkg::ECC_W-1:0]     r_user_o,
  output logic                          r_valid_o,
  output logic [ecc_pkg::ECC_W-1:0]     syndrome_o,
  output logic [1:0]                    err_o,
  // target side, plain data without check bits
  output logic                          fifo_req_o,
  input  logic                          fifo_gnt_i,
  output logic [ecc_pkg::ADDR_W-1:0]    fifo_add_o,
  output logic                          fifo_wen_o,
  output logic [ecc_pkg::DATA_W-1:0]    fifo_data_o,
  output logic [ecc_pkg::BE_W-1:0]      fifo_be_o,
  input  logic [ecc_pkg::DATA_W-1:0]    mem_r_data_i,
  input  logic                          mem_r_valid_i
);

  import ecc_pkg::*;

  ecc_codeword_u in_cw;

  // request controls go straight through, no latency is added here
  assign fifo_req_o = req_i;
  assign gnt_o = fifo_gnt_i;
  assign fifo_add_o = add_i;
  assign fifo_wen_o = wen_i;
  assign fifo_be_o = be_i;
  assign r_valid_o = mem_r_valid_i;

  // check bits sit above the data, the same order as user over data on the bus
  always_comb begin
    in_cw.fields.ecc = user_i;
    in_cw.fields.data = data_i;
  end

  // write data is replaced by the corrected word, nothing is done on a failed correction
  secded_dec u_dec (
    .cw_i       (in_cw),
    .data_o     (fifo_data_o),
    .syndrome_o (syndrome_o),
    .err_o      (err_o)
  );

  // read data leaves unchanged and gets fresh check bits in the user field
  assign r_data_o = mem_r_data_i;

  secded_enc u_enc (
    .data_i (mem_r_data_i),
    .ecc_o  (r_user_o)
  );

endmodule

// ==== ecc_mem_bank.sv ====
module ecc_mem_bank (
  input  logic                          clk_i,
  input  logic                          reset_i,
  input  logic                          req_i,
  input  logic [ecc_pkg::ADDR_W-1:0]    add_i,
  // high means read, as on the core bus
  input  logic                          wen_i,
  input  logic [ecc_pkg::DATA_W-1:0]    data_i,
  input  logic [ecc_pkg::BE_W-1:0]      be_i,
  output logic [ecc_pkg::DATA_W-1:0]    r_data_o,
  output logic                          r_valid_o
);

  import ecc_pkg::*;

  // storage holds plain data, the check bits are regenerated on the way out
  logic [DATA_W-1:0] mem_q [MEM_WORDS];

  logic wr_en;
  logic rd_en;

  // the bank is always ready, every request is taken on the next edge
  assign wr_en = req_i & ~wen_i;
  assign rd_en = req_i & wen_i;

  // a write only touches the bytes whose enable is set
  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      for (int unsigned b = 0; b < BE_W; b++) begin
        if (be_i[b]) begin
          mem_q[add_i][b*BYTE_W +: BYTE_W] <= data_i[b*BYTE_W +: BYTE_W];
        end
      end
    end
  end

  // read data is registered and holds its value until the next read
  always_ff @(posedge clk_i) begin
    if (rd_en) begin
      r_data_o <= mem_q[add_i];
    end
  end

  // one valid pulse per read, writes give no response
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      r_valid_o <= 1'b0;
    end else begin
      r_valid_o <= rd_en;
    end
  end

endmodule

// ==== ecc_mem_checker.sv ====
module ecc_mem_checker (
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  logic                        req_i,
  input  logic                        wen_i,
  input  logic                        r_valid_o,
  input  logic [ecc_pkg::ECC_W-1:0]   syndrome_o,
  input  logic [1:0]                  err_o
);

  timeunit 1ns;
  timeprecision 100ps;

  import ecc_pkg::*;

  // the decoder only knows three error classes
  a_err_code: assert property (@(posedge clk_i) disable iff (reset_i) err_o != 2'b11)
    else $error("err_o reported the unused code 11");

  // the bank clears its valid flag in reset, so no response follows it
  a_no_valid_after_reset: assert property (@(posedge clk_i) reset_i |=> !r_valid_o)
    else $error("r_valid_o was high in the cycle after reset");

  // a clean write must decode to an all zero syndrome
  a_clean_syndrome: assert property (@(posedge clk_i) disable iff (reset_i)
    (req_i && !wen_i && err_o == ERR_NONE) |-> syndrome_o == '0)
    else $error("syndrome_o nonzero on a write without error");

endmodule

bind ecc_mem_subsys ecc_mem_checker u_checker (
  .clk_i      (clk_i),
  .reset_i    (reset_i),
  .req_i      (req_i),
  .wen_i      (wen_i),
  .r_valid_o  (r_valid_o),
  .syndrome_o (syndrome_o),
  .err_o      (err_o)
);

// ==== ecc_mem_subsys.sv ====
module ecc_mem_subsys (
  input  logic                          clk_i,
  input  logic                          reset_i,
  // core bus with SECDED check bits in the user field
  input  logic                          req_i,
  output logic                          gnt_o,
  input  logic [ecc_pkg::ADDR_W-1:0]    add_i,
  input  logic                          wen_i,
  input  logic [ecc_pkg::DATA_W-1:0]    data_i,
  input  logic [ecc_pkg::BE_W-1:0]      be_i,
  input  logic [ecc_pkg::ECC_W-1:0]     user_i,
  output logic [ecc_pkg::DATA_W-1:0]    r_data_o,
  output logic [ecc_pkg::ECC_W-1:0]     r_user_o,
  output logic                          r_valid_o,
  output logic [ecc_pkg::ECC_W-1:0]     syndrome_o,
  output logic [1:0]                    err_o
);

  import ecc_pkg::*;

  // shim to request buffer
  logic              fifo_req;
  logic              fifo_gnt;
  logic [ADDR_W-1:0] fifo_add;
  logic              fifo_wen;
  logic [DATA_W-1:0] fifo_data;
  logic [BE_W-1:0]   fifo_be;

  // request buffer to bank
  logic              mem_req;
  logic [ADDR_W-1:0] mem_add;
  logic              mem_wen;
  logic [DATA_W-1:0] mem_data;
  logic [BE_W-1:0]   mem_be;

  // bank response back to the shim
  logic [DATA_W-1:0] mem_r_data;
  logic              mem_r_valid;

  ecc_bus_dec u_bus_dec (
    .req_i         (req_i),
    .gnt_o         (gnt_o),
    .add_i         (add_i),
    .wen_i         (wen_i),
    .data_i        (data_i),
    .be_i          (be_i),
    .user_i        (user_i),
    .r_data_o      (r_data_o),
    .r_user_o      (r_user_o),
    .r_valid_o     (r_valid_o),
    .syndrome_o    (syndrome_o),
    .err_o         (err_o),
    .fifo_req_o    (fifo_req),
    .fifo_gnt_i    (fifo_gnt),
    .fifo_add_o    (fifo_add),
    .fifo_wen_o    (fifo_wen),
    .fifo_data_o   (fifo_data),
    .fifo_be_o     (fifo_be),
    .mem_r_data_i  (mem_r_data),
    .mem_r_valid_i (mem_r_valid)
  );

  ecc_req_fifo u_req_fifo (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .push_req_i  (fifo_req),
    .push_gnt_o  (fifo_gnt),
    .push_add_i  (fifo_add),
    .push_wen_i  (fifo_wen),
    .push_data_i (fifo_data),
    .push_be_i   (fifo_be),
    .pop_req_o   (mem_req),
    .pop_add_o   (mem_add),
    .pop_wen_o   (mem_wen),
    .pop_data_o  (mem_data),
    .pop_be_o    (mem_be)
  );

  ecc_mem_bank u_mem_bank (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .req_i     (mem_req),
    .add_i     (mem_add),
    .wen_i     (mem_wen),
    .data_i    (mem_data),
    .be_i      (mem_be),
    .r_data_o  (mem_r_data),
    .r_valid_o (mem_r_valid)
  );

endmodule

// ==== ecc_pkg.sv ====
package ecc_pkg;

  // data word and check bits of the 39/32 SECDED code
  localparam int unsigned DATA_W = 32;
  localparam int unsigned ECC_W = 7;
  // the top check bit is overall parity and the six below it are Hamming checks
  localparam int unsigned HAM_W = ECC_W - 1;
  localparam int unsigned CW_W = DATA_W + ECC_W;

  // word addressed bank with byte enables
  localparam int unsigned ADDR_W = 8;
  localparam int unsigned BYTE_W = 8;
  localparam int unsigned BE_W = DATA_W / BYTE_W;
  localparam int unsigned MEM_WORDS = 256;

  // request buffer between the shim and the bank
  localparam int unsigned FIFO_DEPTH = 2;
  localparam int unsigned PTR_W = $clog2(FIFO_DEPTH);
  localparam int unsigned CNT_W = $clog2(FIFO_DEPTH + 1);

  // error classes reported by the decoder
  localparam logic [1:0] ERR_NONE = 2'b00;
  localparam logic [1:0] ERR_SINGLE = 2'b01;
  localparam logic [1:0] ERR_DOUBLE = 2'b10;

  // field view follows the bus layout with user bits above the data bits
  // and the flat view is the raw codeword
  typedef union packed {
    struct packed {
      logic [ECC_W-1:0]  ecc;
      logic [DATA_W-1:0] data;
    } fields;
    logic [CW_W-1:0] flat;
  } ecc_codeword_u;

  // position of data bit j, counting only non power of two positions from 3 up
  function automatic logic [HAM_W-1:0] data_pos(input int unsigned j);
    int unsigned cnt;
    logic [HAM_W-1:0] pos;
    cnt = 0;
    pos = '0;
    for (int unsigned p = 3; p < CW_W; p++) begin
      // a power of two position holds a check bit and is skipped
      if ((p & (p - 1)) != 0) begin
        if (cnt == j) begin
          pos = HAM_W'(p);
        end
        cnt++;
      end
    end
    return pos;
  endfunction

  // Hamming check k is the parity of every data bit whose position has bit k set
  function automatic logic [HAM_W-1:0] calc_checks(input logic [DATA_W-1:0] data);
    logic [HAM_W-1:0] chk;
    logic [HAM_W-1:0] pos;
    chk = '0;
    for (int unsigned j = 0; j < DATA_W; j++) begin
      pos = data_pos(j);
      for (int unsigned k = 0; k < HAM_W; k++) begin
        if (pos[k]) begin
          chk[k] = chk[k] ^ data[j];
        end
      end
    end
    return chk;
  endfunction

endpackage

// ==== ecc_req_fifo.sv ====
module ecc_req_fifo (
  input  logic                          clk_i,
  input  logic                          reset_i,
  // push side from the ECC shim
  input  logic                          push_req_i,
  output logic                          push_gnt_o,
  input  logic [ecc_pkg::ADDR_W-1:0]    push_add_i,
  input  logic                          push_wen_i,
  input  logic [ecc_pkg::DATA_W-1:0]    push_data_i,
  input  logic [ecc_pkg::BE_W-1:0]      push_be_i,
  // pop side towards the memory bank, driven from the head entry
  output logic                          pop_req_o,
  output logic [ecc_pkg::ADDR_W-1:0]    pop_add_o,
  output logic                          pop_wen_o,
  output logic [ecc_pkg::DATA_W-1:0]    pop_data_o,
  output logic [ecc_pkg::BE_W-1:0]      pop_be_o
);

  import ecc_pkg::*;

  // entry storage, one array per request field
  logic [ADDR_W-1:0] add_q  [FIFO_DEPTH];
  logic              wen_q  [FIFO_DEPTH];
  logic [DATA_W-1:0] data_q [FIFO_DEPTH];
  logic [BE_W-1:0]   be_q   [FIFO_DEPTH];

  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic push;
  logic pop;

  // grant follows free space only and does not look at the request
  assign push_gnt_o = (count_q != CNT_W'(FIFO_DEPTH));
  assign push = push_req_i & push_gnt_o;

  // the bank takes one request per cycle, so the head leaves whenever it is valid
  assign pop_req_o = (count_q != '0);
  assign pop = pop_req_o;

  assign pop_add_o = add_q[rd_ptr_q];
  assign pop_wen_o = wen_q[rd_ptr_q];
  assign pop_data_o = data_q[rd_ptr_q];
  assign pop_be_o = be_q[rd_ptr_q];

  // payload is written at the tail on an accepted push
  always_ff @(posedge clk_i) begin
    if (push) begin
      add_q[wr_ptr_q] <= push_add_i;
      wen_q[wr_ptr_q] <= push_wen_i;
      data_q[wr_ptr_q] <= push_data_i;
      be_q[wr_ptr_q] <= push_be_i;
    end
  end

  // pointers wrap naturally since the depth is a power of two
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + PTR_W'(1);
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + PTR_W'(1);
      end
      // a push and a pop in the same cycle leave the count unchanged
      case ({push, pop})
        2'b10:   count_q <= count_q + CNT_W'(1);
        2'b01:   count_q <= count_q - CNT_W'(1);
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

// ==== list.f ====
ecc_pkg.sv
secded_enc.sv
secded_dec.sv
ecc_bus_dec.sv
ecc_req_fifo.sv
ecc_mem_bank.sv
ecc_mem_subsys.sv
ecc_mem_checker.sv
tb_ecc_mem_subsys.sv

// ==== secded_dec.sv ====
module secded_dec (
  input  ecc_pkg::ecc_codeword_u        cw_i,
  output logic [ecc_pkg::DATA_W-1:0]    data_o,
  output logic [ecc_pkg::ECC_W-1:0]     syndrome_o,
  output logic [1:0]                    err_o
);

  import ecc_pkg::*;

  logic [HAM_W-1:0] syn_ham;
  logic overall;
  logic [HAM_W-1:0] recomputed;

  // recompute the checks from the received data bits
  assign recomputed = calc_checks(cw_i.fields.data);

  // the low syndrome bits point at the failing position, zero if none
  assign syn_ham = recomputed ^ cw_i.fields.ecc[HAM_W-1:0];

  // a clean codeword has even parity over all 39 bits
  // so any odd number of flips shows up here
  assign overall = ^cw_i.flat;

  assign syndrome_o = {overall, syn_ham};

  // an odd parity means exactly one flip, wherever it sits
  // even parity with a nonzero syndrome means two flips
  always_comb begin
    err_o = ERR_NONE;
    if (overall) begin
      err_o = ERR_SINGLE;
    end else if (syn_ham != '0) begin
      err_o = ERR_DOUBLE;
    end
  end

  // only a single error is corrected
  // a position that is a check bit or outside the data leaves the data alone
  always_comb begin
    data_o = cw_i.fields.data;
    if (overall) begin
      for (int unsigned j = 0; j < DATA_W; j++) begin
        if (syn_ham == data_pos(j)) begin
          data_o[j] = ~cw_i.fields.data[j];
        end
      end
    end
  end

  // with a double error the data passes through as received
  // and it is up to the initiator to act on err_o

endmodule

// ==== secded_enc.sv ====
module secded_enc (
  input  logic [ecc_pkg::DATA_W-1:0] data_i,
  output logic [ecc_pkg::ECC_W-1:0]  ecc_o
);

  import ecc_pkg::*;

  // codeword with the overall parity bit still cleared
  ecc_codeword_u cw_part;
  logic [HAM_W-1:0] checks;
  logic overall;

  // the position tables are constant, so the function unrolls into
  // six plain XOR trees over the data bits
  assign checks = calc_checks(data_i);

  always_comb begin
    cw_part.fields.data = data_i;
    cw_part.fields.ecc = {1'b0, checks};
  end

  // overall parity covers data and the six Hamming checks
  // so that the complete codeword ends up with even parity
  assign overall = ^cw_part.flat;

  // parity bit goes on top, in the same order as the decoder expects
  assign ecc_o = {overall, checks};

endmodule

// ==== tb_ecc_mem_subsys.sv ====
module tb_ecc_mem_subsys;

  timeunit 1ns;
  timeprecision 100ps;

  import ecc_pkg::*;

  localparam int TIMEOUT = 50;

  logic clk_i;
  logic reset_i;
  logic req_i;
  logic gnt_o;
  logic [ADDR_W-1:0] add_i;
  logic wen_i;
  logic [DATA_W-1:0] data_i;
  logic [BE_W-1:0] be_i;
  logic [ECC_W-1:0] user_i;
  logic [DATA_W-1:0] r_data_o;
  logic [ECC_W-1:0] r_user_o;
  logic r_valid_o;
  logic [ECC_W-1:0] syndrome_o;
  logic [1:0] err_o;

  // stimulus table with one entry per bus request where a zero data word means random data
  logic              rd_tab [$];
  logic [ADDR_W-1:0] addr_tab [$];
  logic [BE_W-1:0]   be_tab [$];
  logic [DATA_W-1:0] data_tab [$];
  logic [CW_W-1:0]   flip_tab [$];
  logic [1:0]        err_tab [$];

  // expected memory contents and read data still owed by the DUT
  logic [DATA_W-1:0] shadow [MEM_WORDS];
  logic [DATA_W-1:0] exp_reads [$];
  logic [DATA_W-1:0] rd_expected;
  integer seed = 65;
  int errors = 0;
  int timeouts = 0;

  ecc_mem_subsys u_dut (.*);

  initial clk_i = 1'b0;
  always #2 clk_i = ~clk_i;

  // position of data bit j among the non power of two positions from 3 up
  function automatic int hamming_pos(input int j);
    int cnt;
    int result;
    cnt = 0;
    result = 0;
    for (int p = 3; p < 39; p++) begin
      if ((p & (p - 1)) != 0) begin
        if (cnt == j) begin
          result = p;
        end
        cnt++;
      end
    end
    return result;
  endfunction

  // six Hamming checks with the overall parity bit on top
  function automatic logic [6:0] ref_encode(input logic [31:0] data);
    logic [5:0] chk;
    int pos;
    chk = '0;
    for (int j = 0; j < 32; j++) begin
      pos = hamming_pos(j);
      for (int k = 0; k < 6; k++) begin
        if (pos[k] && data[j]) begin
          chk[k] = ~chk[k];
        end
      end
    end
    return {^{chk, data}, chk};
  endfunction

  // each flipped bit adds its position to the low syndrome while the overall bit adds none
  function automatic logic [6:0] exp_syndrome(input logic [38:0] mask);
    logic [5:0] low;
    low = '0;
    for (int i = 0; i < 39; i++) begin
      if (mask[i] && i < 32) begin
        low = low ^ 6'(hamming_pos(i));
      end else if (mask[i] && i < 38) begin
        low = low ^ (6'd1 << (i - 32));
      end
    end
    return {^mask, low};
  endfunction

  task automatic add_entry(input logic rd, input logic [7:0] addr, input logic [3:0] be,
                           input logic [31:0] data, input logic [38:0] flip,
                           input logic [1:0] err);
    rd_tab.push_back(rd);
    addr_tab.push_back(addr);
    be_tab.push_back(be);
    data_tab.push_back(data);
    flip_tab.push_back(flip);
    err_tab.push_back(err);
  endtask

  task automatic check_value(input string name, input logic [63:0] exp,
                             input logic [63:0] act);
    if (exp !== act) begin
      $display("ERR %0t %s expected %0h actual %0h", $time, name, exp, act);
      errors++;
    end
  endtask

  // gnt_o only moves on a rising edge and is sampled in the middle of the cycle
  task automatic wait_grant(output bit ok);
    int cycles;
    cycles = 0;
    while (!gnt_o && cycles < TIMEOUT) begin
      @(negedge clk_i);
      #1;
      cycles++;
    end
    ok = gnt_o;
    if (!ok) begin
      $display("timeout: gnt_o stayed low for %0d cycles at %0t", TIMEOUT, $time);
      timeouts++;
    end
  endtask

  // read responses come back in request order
  always @(negedge clk_i) begin
    if (!reset_i && r_valid_o) begin
      if (exp_reads.size() == 0) begin
        $display("a read response arrived with no read outstanding at %0t", $time);
        errors++;
      end else begin
        rd_expected = exp_reads.pop_front();
        check_value("r_data_o", 64'(rd_expected), 64'(r_data_o));
        check_value("r_user_o", 64'(ref_encode(rd_expected)), 64'(r_user_o));
      end
    end
  end

  initial begin
    logic [DATA_W-1:0] d;
    logic [DATA_W-1:0] stored;
    logic [CW_W-1:0] cw;
    bit ok;
    int cycles;
    reset_i = 1'b1;
    req_i = 1'b0;
    add_i = '0;
    wen_i = 1'b1;
    data_i = '0;
    be_i = '0;
    user_i = '0;
    ok = 1'b1;
    // clean accesses come first and then single flips, double flips and partial writes
    add_entry(1'b0, 8'h10, 4'hf, 32'h0, 39'h00_0000_0000, 2'b00);
    add_entry(1'b1, 8'h10, 4'h0, 32'h0, 39'h00_0000_0000, 2'b00);
    add_entry(1'b0, 8'h11, 4'hf, 32'ha5a5_1234, 39'h00_0000_0020, 2'b01);
    add_entry(1'b1, 8'h11, 4'h0, 32'h0, 39'h00_0000_0000, 2'b00);
    add_entry(1'b0, 8'h12, 4'hf, 32'h0, 39'h02_0000_0000, 2'b01);
    add_entry(1'b0, 8'h13, 4'hf, 32'h0, 39'h40_0000_0000, 2'b01);
    add_entry(1'b1, 8'h12, 4'h0, 32'h0, 39'h00_0000_0000, 2'b00);
    add_entry(1'b1, 8'h13, 4'h0, 32'h0, 39'h00_0000_0000, 2'b00);
    add_entry(1'b0, 8'h14, 4'hf, 32'h0f0f_f0f0, 39'h00_0010_0001, 2'b10);
    add_entry(1'b1, 8'h14, 4'h0, 32'h0, 39'h00_0000_0000, 2'b00);
    add_entry(1'b0, 8'h14, 4'h5, 32'h0, 39'h00_0000_0000, 2'b00);
    add_entry(1'b0, 8'h10, 4'h8, 32'hdead_beef, 39'h00_0000_0000, 2'b00);
    add_entry(1'b1, 8'h14, 4'h0, 32'h0, 39'h00_0000_0000, 2'b00);
    add_entry(1'b1, 8'h10, 4'h0, 32'h0, 39'h00_0000_0000, 2'b00);
    add_entry(1'b0, 8'h15, 4'hf, 32'h0, 39'h08_0000_0004, 2'b10);
    add_entry(1'b1, 8'h15, 4'h0, 32'h0, 39'h00_0000_0000, 2'b00);
    add_entry(1'b1, 8'h11, 4'h0, 32'h0, 39'h00_0000_0000, 2'b00);
    // three rising edges see reset high before it drops on a falling edge
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;
    // req_i stays high from the first entry to the last
    for (int i = 0; i < rd_tab.size(); i++) begin
      @(negedge clk_i);
      d = (data_tab[i] == '0) ? DATA_W'($random(seed)) : data_tab[i];
      cw = {ref_encode(d), d} ^ flip_tab[i];
      req_i = 1'b1;
      add_i = addr_tab[i];
      wen_i = rd_tab[i];
      be_i = be_tab[i];
      data_i = rd_tab[i] ? '0 : cw[31:0];
      user_i = rd_tab[i] ? '0 : cw[38:32];
      #1;
      if (!rd_tab[i]) begin
        check_value("err_o", 64'(err_tab[i]), 64'(err_o));
        check_value("syndrome_o", 64'(exp_syndrome(flip_tab[i])), 64'(syndrome_o));
      end
      // with one push and one pop per cycle the FIFO never fills and the grant stays high
      check_value("gnt_o", 64'(1'b1), 64'(gnt_o));
      wait_grant(ok);
      if (!ok) begin
        break;
      end
      // a double error is stored as the raw data bits that were sent
      stored = (err_tab[i] == 2'b10) ? cw[31:0] : d;
      if (rd_tab[i]) begin
        exp_reads.push_back(shadow[addr_tab[i]]);
      end else begin
        for (int b = 0; b < 4; b++) begin
          if (be_tab[i][b]) begin
            shadow[addr_tab[i]][b*8 +: 8] = stored[b*8 +: 8];
          end
        end
      end
    end
    @(negedge clk_i);
    req_i = 1'b0;
    cycles = 0;
    while (exp_reads.size() != 0 && cycles < TIMEOUT) begin
      @(negedge clk_i);
      cycles++;
    end
    if (exp_reads.size() != 0) begin
      $display("timeout: %0d read responses never arrived", exp_reads.size());
      timeouts++;
    end
    $display("errors: %0d mismatches, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule
